/* common/vec_defs.svh */
/*
  Build-time sizes of the vector coprocessor
  VEC_VL must stay equal to lanes times slots
  Lane count must be even for the two-level reduction tree
  Slot count must be a power of two so the slot counter wraps cleanly
*/
`ifndef VEC_DEFS_SVH
`define VEC_DEFS_SVH

////////////////////////////////////////
// Datapath sizes
////////////////////////////////////////

// Parallel lanes
`define VEC_NR_LANES 4

// Element width in bits
`define VEC_ELEM_W 16

////////////////////////////////////////
// Register file shape
////////////////////////////////////////

// Architectural vector registers
`define VEC_NR_VREGS 8

// Elements of one register held by each lane
`define VEC_SLOTS 4

// Elements per vector register
`define VEC_VL (`VEC_NR_LANES * `VEC_SLOTS)

`endif

/* common/vec_pkg.sv */
/*
  Types shared by the vector coprocessor blocks
  Opcode values not listed in vec_op_e are illegal
  Both instruction forms keep the opcode in the top four bits
*/
`default_nettype none
`include "vec_defs.svh"

package vec_pkg;

  typedef logic [`VEC_ELEM_W-1:0]              elem_t;
  typedef logic [$clog2(`VEC_NR_VREGS)-1:0]    vreg_idx_t;
  typedef logic [$clog2(`VEC_SLOTS)-1:0]       slot_t;
  // One extra bit so out-of-range indices can be seen
  typedef logic [$clog2(`VEC_VL):0]            elem_idx_t;

  typedef enum logic [3:0] {
    VSPLAT  = 4'd0,
    VID     = 4'd1,
    VADD    = 4'd2,
    VAND    = 4'd3,
    VREDSUM = 4'd4,
    VREDMAX = 4'd5,
    VEXT    = 4'd6
  } vec_op_e;

  ////////////////////////////////////////
  // Instruction word
  ////////////////////////////////////////

  // Register form
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    logic [2:0] pad;
  } insn_vv_t;

  // Index form, used by VEXT
  typedef struct packed {
    vec_op_e    op;
    vreg_idx_t  vs2;
    elem_idx_t  idx;
    logic [3:0] pad;
  } insn_idx_t;

  typedef union packed {
    insn_vv_t  vv;
    insn_idx_t idx;
  } insn_u;

  ////////////////////////////////////////
  // Core port
  ////////////////////////////////////////

  typedef struct packed {
    logic  valid;
    insn_u insn;
    elem_t scalar;
  } acc_req_t;

  typedef struct packed {
    logic  valid;
    logic  error;
    elem_t data;
  } acc_resp_t;

  ////////////////////////////////////////
  // Internal traffic
  ////////////////////////////////////////

  typedef struct packed {
    logic      valid;
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
    elem_idx_t elem_idx;
  } seq_req_t;

  typedef struct packed {
    logic      valid;
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
    elem_idx_t elem_idx;
    slot_t     slot;
    logic      last;
  } lane_cmd_t;

  typedef struct packed {
    logic  valid;
    elem_t value;
  } lane_part_t;

  typedef struct packed {
    logic  valid;
    elem_t data;
  } red_resp_t;

endpackage

`default_nettype wire

/* design/vec_dispatcher.sv */
/*
  Front end towards the scalar core
  One instruction in flight; strobes seen while busy are answered with an error
  Completion is reported VEC_SLOTS + 4 cycles after acceptance
  An error that meets a completion on the same edge is sent one cycle later
*/
`timescale 1ns/1ps
`default_nettype none
`include "vec_defs.svh"

module vec_dispatcher import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  acc_req_t  acc_req_i,
  output acc_resp_t acc_resp_o,
  output logic      busy_o,
  output seq_req_t  seq_req_o,
  input  logic      seq_done_i,
  input  red_resp_t red_resp_i
);

  seq_req_t  dec;
  logic      legal;
  logic      is_data;
  logic      accept;
  logic      reject;

  seq_req_t  seq_pay_q;
  logic      seq_valid_q;
  logic      busy_q;
  logic      data_op_q;
  logic      done_q;
  logic      err_pend_q;
  acc_resp_t resp_q;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  always_comb begin
    dec          = '0;
    dec.op       = acc_req_i.insn.vv.op;
    dec.vd       = acc_req_i.insn.vv.vd;
    dec.vs1      = acc_req_i.insn.vv.vs1;
    dec.vs2      = acc_req_i.insn.vv.vs2;
    dec.scalar   = acc_req_i.scalar;
    legal        = 1'b1;
    is_data      = 1'b0;
    case (acc_req_i.insn.vv.op)
      VSPLAT, VID, VADD, VAND: legal = 1'b1;
      VREDSUM, VREDMAX:        is_data = 1'b1;
      VEXT: begin
        // Index form carries vs2 and the element number
        dec.vs2      = acc_req_i.insn.idx.vs2;
        dec.elem_idx = acc_req_i.insn.idx.idx;
        legal        = acc_req_i.insn.idx.idx < elem_idx_t'(`VEC_VL);
        is_data      = 1'b1;
      end
      default: legal = 1'b0;
    endcase
    dec.valid = 1'b1;
  end

  assign accept = acc_req_i.valid && !busy_q && legal;
  assign reject = acc_req_i.valid && !accept;

  ////////////////////////////////////////
  // Request to the sequencer
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      seq_pay_q <= dec;
    end
  end

  always_comb begin
    seq_req_o       = seq_pay_q;
    seq_req_o.valid = seq_valid_q;
  end

  ////////////////////////////////////////
  // Busy tracking and response
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      seq_valid_q <= 1'b0;
      busy_q      <= 1'b0;
      data_op_q   <= 1'b0;
      done_q      <= 1'b0;
      err_pend_q  <= 1'b0;
      resp_q      <= '0;
    end else begin
      seq_valid_q <= accept;
      // Delay done so the reduction result lines up with it
      done_q      <= seq_done_i;
      if (accept) begin
        busy_q    <= 1'b1;
        data_op_q <= is_data;
      end else if (done_q) begin
        busy_q    <= 1'b0;
      end

      resp_q <= '0;
      if (done_q) begin
        resp_q.valid <= 1'b1;
        resp_q.data  <= (data_op_q && red_resp_i.valid) ? red_resp_i.data : '0;
        err_pend_q   <= reject;
      end else if (reject || err_pend_q) begin
        resp_q.valid <= 1'b1;
        resp_q.error <= 1'b1;
        err_pend_q   <= reject && err_pend_q;
      end
    end
  end

  assign acc_resp_o = resp_q;
  assign busy_o     = busy_q;

endmodule

`default_nettype wire

/* design/vec_reduce.sv */
/*
  Cross-lane combine of the lane partials
  Two-level tree; assumes an even number of lanes
  Sum mode also serves VEXT, since idle lanes give zero
  Result is registered one cycle after the lane strobes
*/
`timescale 1ns/1ps
`default_nettype none
`include "vec_defs.svh"

module vec_reduce import vec_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  lane_part_t [`VEC_NR_LANES-1:0] lane_part_i,
  input  logic                           red_max_i,
  output red_resp_t                      red_resp_o
);

  localparam int unsigned NrPairs = `VEC_NR_LANES / 2;

  elem_t                    lvl1 [NrPairs];
  elem_t                    lvl2;
  logic [`VEC_NR_LANES-1:0] lane_valid;
  logic                     valid_q;
  elem_t                    data_q;

  function automatic elem_t combine(elem_t a, elem_t b, logic take_max);
    elem_t res;
    if (take_max) begin
      res = (a > b) ? a : b;
    end else begin
      res = a + b;
    end
    return res;
  endfunction

  ////////////////////////////////////////
  // Combine tree
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NrPairs; i++) begin
      lvl1[i] = combine(lane_part_i[2*i].value, lane_part_i[2*i+1].value, red_max_i);
    end
    lvl2 = lvl1[0];
    for (int i = 1; i < NrPairs; i++) begin
      lvl2 = combine(lvl2, lvl1[i], red_max_i);
    end
    for (int i = 0; i < `VEC_NR_LANES; i++) begin
      lane_valid[i] = lane_part_i[i].valid;
    end
  end

  // Lanes strobe together
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= &lane_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (&lane_valid) begin
      data_q <= lvl2;
    end
  end

  assign red_resp_o.valid = valid_q;
  assign red_resp_o.data  = data_q;

endmodule

`default_nettype wire

/* design/vec_sequencer.sv */
/*
  Walks the element slots of the accepted instruction
  One lane command per cycle, broadcast to every lane
  Done pulses one cycle after the last command
  A new request is only expected once the previous one has completed
*/
`timescale 1ns/1ps
`default_nettype none
`include "vec_defs.svh"

module vec_sequencer import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  seq_req_t  seq_req_i,
  output lane_cmd_t lane_cmd_o,
  output logic      seq_done_o,
  output logic      red_max_o
);

  seq_req_t req_q;
  logic     active_q;
  logic     done_q;
  slot_t    slot_q;
  logic     last;

  assign last = slot_q == slot_t'(`VEC_SLOTS - 1);

  // Latched instruction fields
  always_ff @(posedge clk_i) begin
    if (seq_req_i.valid) begin
      req_q <= seq_req_i;
    end
  end

  ////////////////////////////////////////
  // Slot counter
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      slot_q   <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= active_q && last;
      if (seq_req_i.valid) begin
        active_q <= 1'b1;
        slot_q   <= '0;
      end else if (active_q) begin
        if (last) begin
          active_q <= 1'b0;
          slot_q   <= '0;
        end else begin
          slot_q <= slot_q + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Lane command
  ////////////////////////////////////////

  always_comb begin
    lane_cmd_o.valid    = active_q;
    lane_cmd_o.op       = req_q.op;
    lane_cmd_o.vd       = req_q.vd;
    lane_cmd_o.vs1      = req_q.vs1;
    lane_cmd_o.vs2      = req_q.vs2;
    lane_cmd_o.scalar   = req_q.scalar;
    lane_cmd_o.elem_idx = req_q.elem_idx;
    lane_cmd_o.slot     = slot_q;
    lane_cmd_o.last     = active_q && last;
  end

  assign seq_done_o = done_q;

  // Tells the reduction tree which combine to use
  assign red_max_o = req_q.op == VREDMAX;

endmodule

`default_nettype wire

/* design/vec_top.sv */
/*
  Vector coprocessor top level
  The core sends single-cycle strobes and gets one response per strobe
  No back-pressure; watch busy_o before sending
*/
`timescale 1ns/1ps
`default_nettype none
`include "vec_defs.svh"

module vec_top import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  acc_req_t  acc_req_i,
  output acc_resp_t acc_resp_o,
  output logic      busy_o
);

  seq_req_t                         seq_req;
  logic                             seq_done;
  logic                             red_max;
  lane_cmd_t                        lane_cmd;
  lane_part_t [`VEC_NR_LANES-1:0]   lane_part;
  red_resp_t                        red_resp;

  vec_dispatcher i_dispatcher (
    .clk_i      (clk_i     ),
    .rst_n_i    (rst_n_i   ),
    .acc_req_i  (acc_req_i ),
    .acc_resp_o (acc_resp_o),
    .busy_o     (busy_o    ),
    .seq_req_o  (seq_req   ),
    .seq_done_i (seq_done  ),
    .red_resp_i (red_resp  )
  );

  vec_sequencer i_sequencer (
    .clk_i      (clk_i   ),
    .rst_n_i    (rst_n_i ),
    .seq_req_i  (seq_req ),
    .lane_cmd_o (lane_cmd),
    .seq_done_o (seq_done),
    .red_max_o  (red_max )
  );

  // Same command to every lane
  for (genvar lane = 0; lane < `VEC_NR_LANES; lane++) begin : gen_lanes
    vec_lane #(
      .LaneId(lane)
    ) i_lane (
      .clk_i       (clk_i          ),
      .rst_n_i     (rst_n_i        ),
      .lane_cmd_i  (lane_cmd       ),
      .lane_part_o (lane_part[lane])
    );
  end

  vec_reduce i_reduce (
    .clk_i       (clk_i    ),
    .rst_n_i     (rst_n_i  ),
    .lane_part_i (lane_part),
    .red_max_i   (red_max  ),
    .red_resp_o  (red_resp )
  );

endmodule

`default_nettype wire

/* lane/vec_lane.sv */
/*
  One lane: a slice of every vector register plus its element ALU
  Element i of a register lives in lane i mod lanes, slot i div lanes
  Register contents are undefined until written
  The partial result is valid for one cycle after the last command
*/
`timescale 1ns/1ps
`default_nettype none
`include "vec_defs.svh"

module vec_lane import vec_pkg::*; #(
  parameter int unsigned LaneId = 0
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  lane_cmd_t  lane_cmd_i,
  output lane_part_t lane_part_o
);

  elem_t vrf_q [`VEC_NR_VREGS][`VEC_SLOTS];

  elem_t rs1;
  elem_t rs2;
  elem_t elem_num;
  elem_t wdata;
  elem_t contrib;
  elem_t acc_d;
  elem_t acc_q;
  logic  wr_en;
  logic  red_en;
  logic  part_valid_q;

  ////////////////////////////////////////
  // Operand read
  ////////////////////////////////////////

  assign rs1 = vrf_q[lane_cmd_i.vs1][lane_cmd_i.slot];
  assign rs2 = vrf_q[lane_cmd_i.vs2][lane_cmd_i.slot];

  // Global element number handled in this slot
  assign elem_num = elem_t'(lane_cmd_i.slot) * elem_t'(`VEC_NR_LANES) + elem_t'(LaneId);

  ////////////////////////////////////////
  // Element arithmetic
  ////////////////////////////////////////

  always_comb begin
    wr_en = 1'b1;
    wdata = '0;
    case (lane_cmd_i.op)
      VSPLAT:  wdata = lane_cmd_i.scalar;
      VID:     wdata = elem_num;
      VADD:    wdata = rs1 + rs2;
      VAND:    wdata = rs1 & rs2;
      default: wr_en = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (lane_cmd_i.valid && wr_en) begin
      vrf_q[lane_cmd_i.vd][lane_cmd_i.slot] <= wdata;
    end
  end

  ////////////////////////////////////////
  // Partial reduction
  ////////////////////////////////////////

  always_comb begin
    red_en  = 1'b0;
    contrib = rs2;
    case (lane_cmd_i.op)
      VREDSUM, VREDMAX: red_en = 1'b1;
      VEXT: begin
        // Only the lane holding the element contributes
        red_en  = 1'b1;
        contrib = (elem_num == elem_t'(lane_cmd_i.elem_idx)) ? rs2 : '0;
      end
      default: red_en = 1'b0;
    endcase

    if (lane_cmd_i.slot == '0) begin
      acc_d = contrib;
    end else if (lane_cmd_i.op == VREDMAX) begin
      acc_d = (contrib > acc_q) ? contrib : acc_q;
    end else begin
      acc_d = acc_q + contrib;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lane_cmd_i.valid && red_en) begin
      acc_q <= acc_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      part_valid_q <= 1'b0;
    end else begin
      part_valid_q <= lane_cmd_i.valid && lane_cmd_i.last && red_en;
    end
  end

  assign lane_part_o.valid = part_valid_q;
  assign lane_part_o.value = acc_q;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the vector coprocessor testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f vlog.f --top-module vec_tb -o vec_sim; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/vec_sim +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
exit 1

/* verification/vec_chk.sv */
/*
  Concurrent checks on the coprocessor's core-facing ports
  Completion timing assumes VEC_SLOTS + 4 cycles from the accepting edge
  Error responses to busy-time strobes are not completions
*/
`timescale 1ns/1ps
`default_nettype none
`include "vec_defs.svh"

module vec_chk import vec_pkg::*; (
  input logic      clk_i,
  input logic      rst_n_i,
  input acc_req_t  acc_req_i,
  input acc_resp_t acc_resp_i,
  input logic      busy_i
);

  logic legal;
  logic accepted;
  logic completion;

  // Failure counts, read by the testbench at the end of the run
  int unsigned reset_fails = 0;
  int unsigned rise_fails  = 0;
  int unsigned resp_fails  = 0;
  int unsigned idle_fails  = 0;

  always_comb begin
    case (acc_req_i.insn.vv.op)
      VSPLAT, VID, VADD, VAND, VREDSUM, VREDMAX: legal = 1'b1;
      VEXT:    legal = acc_req_i.insn.idx.idx < elem_idx_t'(`VEC_VL);
      default: legal = 1'b0;
    endcase
  end

  assign accepted   = acc_req_i.valid && !busy_i && legal;
  assign completion = acc_resp_i.valid && !acc_resp_i.error;

  ////////////////////////////////////////
  // Port protocol
  ////////////////////////////////////////

  reset_idle: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !busy_i && !acc_resp_i.valid)
  else begin
    reset_fails++;
    $error("busy or response valid right after reset");
  end

  busy_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accepted |=> busy_i)
  else begin
    rise_fails++;
    $error("busy did not rise after an accepted strobe");
  end

  // Exactly one completion, at the fixed latency
  resp_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accepted |-> ##(`VEC_SLOTS + 4) completion)
  else begin
    resp_fails++;
    $error("accepted strobe got no completion in time");
  end

  accept_before_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    completion |-> $past(accepted, `VEC_SLOTS + 4))
  else begin
    resp_fails++;
    $error("completion without a matching accepted strobe");
  end

  idle_after_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    completion |=> !busy_i)
  else begin
    idle_fails++;
    $error("busy still high after a completion");
  end

endmodule

bind vec_top vec_chk vec_chk_i (
  .clk_i      (clk_i     ),
  .rst_n_i    (rst_n_i   ),
  .acc_req_i  (acc_req_i ),
  .acc_resp_i (acc_resp_o),
  .busy_i     (busy_o    )
);

`default_nettype wire

/* verification/vec_tb.sv */
/*
  Testbench for the vector coprocessor top level
  One instruction at a time; each response is awaited before the next strobe
  A behavioral register file tracks the expected contents
*/
`timescale 1ns/1ps
`default_nettype none
`include "vec_defs.svh"

module vec_tb import vec_pkg::*; ();

  localparam int unsigned NrInsns    = 52;
  localparam int unsigned CycleLimit = NrInsns * 12 + 100;

  logic        clk = 1'b0;
  logic        rst_n;
  acc_req_t    acc_req;
  acc_resp_t   acc_resp;
  logic        busy;

  elem_t       model [`VEC_NR_VREGS][`VEC_VL];
  int unsigned errors      = 0;
  int unsigned cycle_count = 0;

  vec_top vec_top_i (
    .clk_i      (clk     ),
    .rst_n_i    (rst_n   ),
    .acc_req_i  (acc_req ),
    .acc_resp_o (acc_resp),
    .busy_o     (busy    )
  );

  always #50 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CycleLimit) begin
      $display("Timeout: no end of test after %0d cycles", CycleLimit);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Instruction words
  ////////////////////////////////////////

  function automatic logic [15:0] reg_form(input logic [3:0] op, input logic [2:0] vd,
                                           input logic [2:0] vs1, input logic [2:0] vs2);
    return {op, vd, vs1, vs2, 3'b000};
  endfunction

  function automatic logic [15:0] index_form(input logic [2:0] vs2, input logic [4:0] idx);
    return {VEXT, vs2, idx, 4'b0000};
  endfunction

  ////////////////////////////////////////
  // Core-side driving and checking
  ////////////////////////////////////////

  task automatic send_strobe(input logic [15:0] word, input elem_t scalar);
    @(posedge clk);
    #1;
    acc_req.valid  = 1'b1;
    acc_req.insn   = word;
    acc_req.scalar = scalar;
    @(posedge clk);
    #1;
    acc_req = '0;
  endtask

  // Sampled on the falling edge where outputs are settled
  task automatic wait_response(output acc_resp_t resp);
    do begin
      @(negedge clk);
    end while (!acc_resp.valid);
    resp = acc_resp;
  endtask

  task automatic check_response(input acc_resp_t resp, input logic exp_err,
                                input elem_t exp_data);
    assert (resp.error === exp_err) else begin
      $display("FAIL acc_resp_o.error: got %h, expected %h", resp.error, exp_err);
      errors++;
    end
    assert (resp.data === exp_data) else begin
      $display("FAIL acc_resp_o.data: got %h, expected %h", resp.data, exp_data);
      errors++;
    end
  endtask

  task automatic issue_and_check(input logic [15:0] word, input elem_t scalar,
                                 input logic exp_err, input elem_t exp_data);
    acc_resp_t resp;
    send_strobe(word, scalar);
    wait_response(resp);
    check_response(resp, exp_err, exp_data);
  endtask

  ////////////////////////////////////////
  // Operations with model update
  ////////////////////////////////////////

  task automatic splat_reg(input int vd, input elem_t value);
    for (int i = 0; i < `VEC_VL; i++) begin
      model[vd][i] = value;
    end
    issue_and_check(reg_form(VSPLAT, 3'(vd), 3'd0, 3'd0), value, 1'b0, '0);
  endtask

  task automatic index_reg(input int vd);
    for (int i = 0; i < `VEC_VL; i++) begin
      model[vd][i] = elem_t'(i);
    end
    issue_and_check(reg_form(VID, 3'(vd), 3'd0, 3'd0), '0, 1'b0, '0);
  endtask

  task automatic add_regs(input int vd, input int vs1, input int vs2);
    for (int i = 0; i < `VEC_VL; i++) begin
      model[vd][i] = model[vs1][i] + model[vs2][i];
    end
    issue_and_check(reg_form(VADD, 3'(vd), 3'(vs1), 3'(vs2)), '0, 1'b0, '0);
  endtask

  task automatic and_regs(input int vd, input int vs1, input int vs2);
    for (int i = 0; i < `VEC_VL; i++) begin
      model[vd][i] = model[vs1][i] & model[vs2][i];
    end
    issue_and_check(reg_form(VAND, 3'(vd), 3'(vs1), 3'(vs2)), '0, 1'b0, '0);
  endtask

  // Sum wraps at the element width
  task automatic reduce_sum(input int vs2);
    elem_t sum;
    sum = '0;
    for (int i = 0; i < `VEC_VL; i++) begin
      sum = sum + model[vs2][i];
    end
    issue_and_check(reg_form(VREDSUM, 3'd0, 3'd0, 3'(vs2)), '0, 1'b0, sum);
  endtask

  task automatic reduce_max(input int vs2);
    elem_t best;
    best = '0;
    for (int i = 0; i < `VEC_VL; i++) begin
      if (model[vs2][i] > best) begin
        best = model[vs2][i];
      end
    end
    issue_and_check(reg_form(VREDMAX, 3'd0, 3'd0, 3'(vs2)), '0, 1'b0, best);
  endtask

  task automatic extract_elem(input int vs2, input int idx);
    issue_and_check(index_form(3'(vs2), 5'(idx)), '0, 1'b0, model[vs2][idx]);
  endtask

  task automatic expect_reject(input logic [15:0] word);
    issue_and_check(word, elem_t'($urandom), 1'b1, '0);
  endtask

  // A second strobe lands while v5 is being written; v1 must stay intact
  task automatic reject_while_busy(input elem_t value);
    acc_resp_t resp;
    for (int i = 0; i < `VEC_VL; i++) begin
      model[5][i] = model[0][i] + model[0][i];
    end
    send_strobe(reg_form(VADD, 3'd5, 3'd0, 3'd0), '0);
    assert (busy === 1'b1) else begin
      $display("FAIL busy_o: got %h, expected %h", busy, 1'b1);
      errors++;
    end
    send_strobe(reg_form(VSPLAT, 3'd1, 3'd0, 3'd0), value);
    wait_response(resp);
    check_response(resp, 1'b1, '0);
    wait_response(resp);
    check_response(resp, 1'b0, '0);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    elem_t       s1;
    elem_t       s2;
    int          idx;
    int unsigned chk_fails;

    acc_req = '0;
    rst_n   = 1'b0;
    void'($urandom(32'hf167));
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Splat, then read back every element
    s1 = elem_t'($urandom);
    splat_reg(1, s1);
    for (int i = 0; i < `VEC_VL; i++) begin
      extract_elem(1, i);
    end

    // Element index and its sum 0 + 1 + ... + 15
    index_reg(0);
    issue_and_check(reg_form(VREDSUM, 3'd0, 3'd0, 3'd0), '0, 1'b0, 16'd120);
    for (int i = 0; i < `VEC_VL; i++) begin
      issue_and_check(index_form(3'd0, 5'(i)), '0, 1'b0, elem_t'(i));
    end

    // Large splat so that most sums wrap
    s2 = elem_t'($urandom) | 16'hfff8;
    splat_reg(2, s2);
    add_regs(3, 0, 2);
    and_regs(4, 3, 2);
    reduce_sum(3);
    reduce_sum(4);
    idx = int'($urandom_range(`VEC_VL - 1, 0));
    extract_elem(3, idx);
    idx = int'($urandom_range(`VEC_VL - 1, 0));
    extract_elem(4, idx);

    reduce_max(0);
    reduce_max(3);
    reduce_max(4);

    // Refused requests
    expect_reject(reg_form(4'hf, 3'd1, 3'd0, 3'd0));
    expect_reject(index_form(3'd1, 5'd16));
    expect_reject(index_form(3'd1, 5'd31));
    reject_while_busy(~s1);
    reduce_sum(1);
    reduce_sum(5);

    repeat (3) @(posedge clk);
    chk_fails = vec_top_i.vec_chk_i.reset_fails + vec_top_i.vec_chk_i.rise_fails
              + vec_top_i.vec_chk_i.resp_fails + vec_top_i.vec_chk_i.idle_fails;
    $display("Errors: %0d response checks, %0d port assertions", errors, chk_fails);
    if (errors == 0 && chk_fails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
common/vec_pkg.sv
design/vec_dispatcher.sv
design/vec_sequencer.sv
lane/vec_lane.sv
design/vec_reduce.sv
design/vec_top.sv
verification/vec_chk.sv
verification/vec_tb.sv
